// File: files.f
+incdir+verilog
verilog/apb_pkg.sv
verilog/excl_pkg.sv
verilog/shared_data_ram.sv
verilog/excl_monitor.sv
verilog/apb_responder.sv
verilog/excl_mem_top.sv
sim/clk_gen.sv
sim/tb_excl_mem.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the exclusive shared memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_excl_mem -f files.f -o tb_excl_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_excl_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/clk_gen.sv
// clk_gen: free running testbench clock
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// File: sim/tb_excl_mem.sv
// testbench driving directed and random APB traffic against the exclusive shared memory
`timescale 1ns/1ps
`include "excl_mem_macros.svh"

module tb_excl_mem;

    localparam int KIND_READ     = 0;
    localparam int KIND_WRITE    = 1;
    localparam int KIND_LWEX     = 2;
    localparam int KIND_SWEX     = 3;
    localparam int KIND_LWEX_WR  = 4;
    localparam int READY_TIMEOUT = 16;

    logic            clk;
    logic            reset;
    logic            psel;
    logic            penable;
    logic            pwrite;
    apb_pkg::paddr_t paddr;
    apb_pkg::pdata_t pwdata;
    apb_pkg::pdata_t prdata;
    logic            pready;

    // reference word values and lock owner per word (-1 when free)
    apb_pkg::pdata_t mem_model [`EXM_MEM_DEPTH];
    int              lock_owner [`EXM_MEM_DEPTH];

    // expectations shared between the driver and the compare process
    logic            exp_ready;
    logic            exp_compare;
    apb_pkg::pdata_t exp_prdata;

    int data_errors;
    int ready_errors;
    int other_errors;

    clk_gen #(.PERIOD_NS(4.0)) clk_gen_inst (.clk(clk));

    excl_mem_top excl_mem_top_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    task automatic check_data(input string name, input apb_pkg::pdata_t actual,
                              input apb_pkg::pdata_t expected);
        if (actual !== expected) begin
            data_errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_ready(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            ready_errors++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, actual, expected);
        end
    endtask

    // expected prdata of one access and the model update it causes
    function automatic apb_pkg::pdata_t ref_access(input int kind, input int core,
                                                   input int addr,
                                                   input apb_pkg::pdata_t wdata);
        apb_pkg::pdata_t result;
        result = mem_model[addr];
        if (kind == KIND_WRITE) begin
            mem_model[addr] = wdata;
        end else if (kind == KIND_LWEX || kind == KIND_LWEX_WR) begin
            if (lock_owner[addr] < 0) begin
                lock_owner[addr] = core;
            end
        end else if (kind == KIND_SWEX) begin
            if (lock_owner[addr] == core) begin
                mem_model[addr] = wdata;
                lock_owner[addr] = -1;
                result = 16'h0000;
            end else begin
                result = 16'h0001;
            end
        end
        return result;
    endfunction

    function automatic apb_pkg::paddr_t build_paddr(input int kind, input int core,
                                                    input int addr);
        apb_pkg::paddr_t a;
        a = '0;
        a[19] = (kind == KIND_LWEX) || (kind == KIND_LWEX_WR);
        a[18] = (kind == KIND_SWEX);
        a[17:15] = 3'(core);
        a[5:0] = 6'(addr);
        return a;
    endfunction

    task automatic idle_cycles(input int n);
        psel    = 1'b0;
        penable = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    // one setup/access pair entered and left 1 ns after a rising edge
    task automatic run_transfer(input int kind, input int core, input int addr,
                                input apb_pkg::pdata_t wdata, output apb_pkg::pdata_t rd);
        int waited;
        exp_prdata  = ref_access(kind, core, addr, wdata);
        exp_compare = (kind != KIND_WRITE);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = (kind == KIND_WRITE) || (kind == KIND_SWEX) || (kind == KIND_LWEX_WR);
        paddr   = build_paddr(kind, core, addr);
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable   = 1'b1;
        exp_ready = 1'b1;
        waited    = 0;
        @(negedge clk);
        while (pready !== 1'b1 && waited < READY_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (pready !== 1'b1) begin
            other_errors++;
            $display("timeout: pready never rose within %0d cycles at %0t",
                     READY_TIMEOUT, $time);
        end
        rd = prdata;
        @(posedge clk);
        #1;
        exp_ready = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
    endtask

    // compare process sampling in the middle of every cycle
    always @(negedge clk) begin
        check_ready("pready", pready, exp_ready);
        if (pready === 1'b1) begin
            if (exp_compare) begin
                check_data("prdata", prdata, exp_prdata);
            end
        end else begin
            check_data("prdata", prdata, '0);
        end
    end

    initial begin
        apb_pkg::pdata_t rd;
        apb_pkg::pdata_t written [8];
        apb_pkg::pdata_t old_word;
        int kind;

        void'($urandom(88029));
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        exp_ready   = 1'b0;
        exp_compare = 1'b0;
        exp_prdata  = '0;
        data_errors  = 0;
        ready_errors = 0;
        other_errors = 0;
        for (int i = 0; i < `EXM_MEM_DEPTH; i++) begin
            mem_model[i]  = '0;
            lock_owner[i] = -1;
        end

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_cycles(2);

        // plain writes then readback; words 0..7 also seed the random phase
        for (int i = 0; i < 8; i++) begin
            written[i] = 16'(16'h1357 * (i + 1));
            run_transfer(KIND_WRITE, 0, i, written[i], rd);
        end
        run_transfer(KIND_WRITE, 5, 63, 16'h7e3f, rd);
        idle_cycles(1);
        for (int i = 0; i < 8; i++) begin
            run_transfer(KIND_READ, 0, i, '0, rd);
            check_data("readback", rd, written[i]);
        end
        run_transfer(KIND_READ, 3, 63, '0, rd);
        check_data("readback", rd, 16'h7e3f);
        idle_cycles(2);

        // lock and store by the same core then a stale store
        run_transfer(KIND_LWEX, 2, 3, '0, rd);
        check_data("lwex data", rd, written[3]);
        run_transfer(KIND_SWEX, 2, 3, 16'hbeef, rd);
        check_data("swex result", rd, 16'h0000);
        run_transfer(KIND_READ, 2, 3, '0, rd);
        check_data("swex stored", rd, 16'hbeef);
        run_transfer(KIND_SWEX, 2, 3, 16'h1234, rd);
        check_data("swex result", rd, 16'h0001);
        run_transfer(KIND_READ, 2, 3, '0, rd);
        check_data("word kept", rd, 16'hbeef);
        idle_cycles(2);

        // a foreign store fails and a foreign lwex cannot steal the lock
        run_transfer(KIND_LWEX, 1, 5, '0, rd);
        run_transfer(KIND_SWEX, 4, 5, 16'hdead, rd);
        check_data("swex result", rd, 16'h0001);
        run_transfer(KIND_READ, 4, 5, '0, rd);
        check_data("word kept", rd, written[5]);
        run_transfer(KIND_LWEX, 4, 5, '0, rd);
        run_transfer(KIND_SWEX, 1, 5, 16'hcafe, rd);
        check_data("swex result", rd, 16'h0000);
        run_transfer(KIND_READ, 1, 5, '0, rd);
        check_data("swex stored", rd, 16'hcafe);
        idle_cycles(2);

        // store to a word nobody locked
        old_word = written[6];
        run_transfer(KIND_SWEX, 0, 6, 16'h5555, rd);
        check_data("swex result", rd, 16'h0001);
        run_transfer(KIND_READ, 0, 6, '0, rd);
        check_data("word kept", rd, old_word);
        idle_cycles(2);

        // random mix back to back
        for (int n = 0; n < 200; n++) begin
            kind = int'($urandom_range(0, 4));
            run_transfer(kind, int'($urandom_range(0, 7)), int'($urandom_range(0, 7)),
                         16'($urandom), rd);
        end
        idle_cycles(3);

        $display("error counts: data %0d, ready %0d, other %0d",
                 data_errors, ready_errors, other_errors);
        if (data_errors + ready_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/apb_pkg.sv
// apb_pkg: APB address and data types for the shared memory slave
`include "excl_mem_macros.svh"

package apb_pkg;

    // full APB address, carries the exclusive-access fields in its top bits
    typedef logic [`EXM_APB_ADDR_WIDTH-1:0] paddr_t;

    // read and write data word
    typedef logic [`EXM_DATA_WIDTH-1:0] pdata_t;

endpackage

// File: verilog/apb_responder.sv
// APB responder with ready timing, access strobe, memory write enable and read data mux
`timescale 1ns/1ps
`include "excl_mem_macros.svh"

module apb_responder (
    input  logic            clk,
    input  logic            reset,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic            lwex,
    input  logic            swex,
    input  logic            swex_pass,
    input  apb_pkg::pdata_t rdata,
    output logic            access,
    output logic            mem_we,
    output apb_pkg::pdata_t prdata,
    output logic            pready
);

    logic setup_seen;
    logic plain_write;

    // remember the setup cycle so ready comes one cycle later
    // when the synchronous memories have their data
    always_ff @(posedge clk) begin
        if (reset) begin
            setup_seen <= 1'b0;
        end else begin
            setup_seen <= psel && !penable;
        end
    end

    // high only in the first access cycle
    assign pready = psel && penable && setup_seen;
    assign access = pready;

    // an LWEX with pwrite set is only a lock request and its data is dropped
    assign plain_write = pwrite && !lwex && !swex;

    // store on a plain write or on a passing SWEX
    assign mem_we = access && (plain_write || swex_pass);

    always_comb begin
        prdata = '0;
        if (pready) begin
            if (swex) begin
                prdata = swex_pass ? `EXM_SWEX_SUCCESS : `EXM_SWEX_FAIL;
            end else begin
                prdata = rdata;
            end
        end
    end

    // ready only ends a proper setup/access pair
    a_ready_handshake: assert property (
        @(posedge clk) disable iff (reset)
        pready |-> (psel && penable && $past(psel && !penable))
    ) else $error("apb_responder: pready outside an access cycle");

endmodule

// File: verilog/excl_mem_macros.svh
// exclusive shared memory: widths, address field positions and SWEX result codes
`ifndef EXCL_MEM_MACROS_SVH
`define EXCL_MEM_MACROS_SVH

// bus widths
`define EXM_APB_ADDR_WIDTH 20
`define EXM_DATA_WIDTH     16

// memory geometry
`define EXM_MEM_DEPTH      64
`define EXM_MEM_ADDR_BITS  6

// requesting core id carried in the address
`define EXM_CORE_ID_BITS   3

// paddr layout: |19 lwex|18 swex|17..15 core id|...|5..0 word|
`define EXM_LWEX_BIT       19
`define EXM_SWEX_BIT       18
`define EXM_CORE_ID_LSB    15

// read data returned by a store-exclusive
`define EXM_SWEX_SUCCESS   16'h0000
`define EXM_SWEX_FAIL      16'h0001

`endif

// File: verilog/excl_mem_top.sv
// excl_mem_top: APB shared memory with exclusive-access monitor
`timescale 1ns/1ps
`include "excl_mem_macros.svh"

module excl_mem_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apb_pkg::paddr_t paddr,
    input  apb_pkg::pdata_t pwdata,
    output apb_pkg::pdata_t prdata,
    output logic            pready
);

    logic                lwex;
    logic                swex;
    excl_pkg::core_id_t  core_id;
    excl_pkg::mem_addr_t mem_addr;
    logic                access;
    logic                swex_pass;
    logic                mem_we;
    apb_pkg::pdata_t     rdata;

    // address fields
    assign lwex     = paddr[`EXM_LWEX_BIT];
    assign swex     = paddr[`EXM_SWEX_BIT];
    assign core_id  = paddr[`EXM_CORE_ID_LSB +: `EXM_CORE_ID_BITS];
    assign mem_addr = paddr[`EXM_MEM_ADDR_BITS-1:0];

    shared_data_ram shared_data_ram_inst (
        .clk      (clk),
        .mem_addr (mem_addr),
        .wdata    (pwdata),
        .mem_we   (mem_we),
        .rdata    (rdata)
    );

    excl_monitor excl_monitor_inst (
        .clk       (clk),
        .reset     (reset),
        .access    (access),
        .lwex      (lwex),
        .swex      (swex),
        .core_id   (core_id),
        .mem_addr  (mem_addr),
        .swex_pass (swex_pass)
    );

    apb_responder apb_responder_inst (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .lwex      (lwex),
        .swex      (swex),
        .swex_pass (swex_pass),
        .rdata     (rdata),
        .access    (access),
        .mem_we    (mem_we),
        .prdata    (prdata),
        .pready    (pready)
    );

endmodule

// File: verilog/excl_monitor.sv
// excl_monitor: per-word lock flags and the LWEX/SWEX verdict of the shared memory
`timescale 1ns/1ps
`include "excl_mem_macros.svh"

module excl_monitor (
    input  logic                clk,
    input  logic                reset,
    input  logic                access,
    input  logic                lwex,
    input  logic                swex,
    input  excl_pkg::core_id_t  core_id,
    input  excl_pkg::mem_addr_t mem_addr,
    output logic                swex_pass
);

    excl_pkg::lock_flag_t flags [`EXM_MEM_DEPTH];
    excl_pkg::lock_flag_t flag_rd;
    excl_pkg::lock_flag_t own_flag;
    logic                 is_locked;
    logic                 is_locked_self;
    logic                 set_lock;

    // flag value that marks the word as held by the requesting core
    assign own_flag = {1'b0, core_id} + 1'b1;

    assign is_locked      = (flag_rd != '0);
    assign is_locked_self = is_locked && (flag_rd == own_flag);

    // load-exclusive takes a free word only
    assign set_lock = access && lwex && !is_locked;

    // store-exclusive passes only for the lock holder
    assign swex_pass = access && swex && is_locked_self;

    // flag store, read like the data memory so both line up in the access cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `EXM_MEM_DEPTH; i++) begin
                flags[i] <= '0;
            end
            flag_rd <= '0;
        end else begin
            flag_rd <= flags[mem_addr];
            if (set_lock) begin
                flags[mem_addr] <= own_flag;
            end else if (swex_pass) begin
                // a successful store releases the word
                flags[mem_addr] <= '0;
            end
        end
    end

    // an access is either a load-exclusive or a store-exclusive, never both
    a_lwex_swex_excl: assert property (
        @(posedge clk) disable iff (reset)
        access |-> !(lwex && swex)
    ) else $error("excl_monitor: lwex and swex both set on access");

    // registered flag must still match the array when a lock is taken,
    // otherwise another core's lock would be overwritten
    a_no_relock: assert property (
        @(posedge clk) disable iff (reset)
        set_lock |-> (flags[mem_addr] == '0)
    ) else $error("excl_monitor: lock set on a word that is already locked");

    // a passing SWEX always finds its own lock in the array
    a_pass_owned: assert property (
        @(posedge clk) disable iff (reset)
        swex_pass |-> (flags[mem_addr] == own_flag)
    ) else $error("excl_monitor: swex passed without holding the lock");

endmodule

// File: verilog/excl_pkg.sv
// excl_pkg: types of the exclusive-access monitor and the word addressing
`include "excl_mem_macros.svh"

package excl_pkg;

    // word index into the shared memory
    typedef logic [`EXM_MEM_ADDR_BITS-1:0] mem_addr_t;

    // id of the core that issues the access
    typedef logic [`EXM_CORE_ID_BITS-1:0] core_id_t;

    // lock flag per word
    // 0 is free, n locks the word for core n-1
    typedef logic [`EXM_CORE_ID_BITS:0] lock_flag_t;

endpackage

// File: verilog/shared_data_ram.sv
// shared_data_ram: 64-word data store with registered read and single write port
`timescale 1ns/1ps
`include "excl_mem_macros.svh"

module shared_data_ram (
    input  logic                clk,
    input  excl_pkg::mem_addr_t mem_addr,
    input  apb_pkg::pdata_t     wdata,
    input  logic                mem_we,
    output apb_pkg::pdata_t     rdata
);

    apb_pkg::pdata_t mem [`EXM_MEM_DEPTH];

    // address from the setup cycle gives data in the access cycle
    always_ff @(posedge clk) begin
        rdata <= mem[mem_addr];
    end

    // write lands on the edge that ends the access cycle
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= wdata;
        end
    end

    // an unknown write enable would silently corrupt the array
    a_we_known: assert property (
        @(posedge clk) !$isunknown(mem_we)
    ) else $error("shared_data_ram: mem_we is unknown");

endmodule
